// ==== hdl/i2c_bit_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_bit_engine import i2c_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  i2c_phase_t      phase_i,
    input  i2c_tick_t       tick_i,
    input  wire logic       sda_i,
    output logic            sda_o,
    output logic            sda_en_o,
    output logic [7:0]      rdata_o,
    output logic            rvalid_o
);

    logic [7:0] shift_q;
    logic       in_data;            // before the ack slot
    logic       rd_byte_done;

    assign in_data      = phase_i.half_bit < 5'(2 * BITS_PER_BYTE);
    assign rd_byte_done = (phase_i.state == RD_DATA) && tick_i.sample_low
                          && (phase_i.half_bit == 5'(2 * BITS_PER_BYTE));

    // ========================================================================
    // sda driver
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sda_o    <= 1'b1;
            sda_en_o <= 1'b0;
        end else begin
            case (phase_i.state)
                W_START: begin
                    if (tick_i.sample_high) begin   // sda falls while scl high
                        sda_o    <= 1'b0;
                        sda_en_o <= 1'b1;
                    end
                end
                R_START: begin
                    if (tick_i.sample_low) begin    // let the line go high first
                        sda_o    <= 1'b1;
                        sda_en_o <= 1'b0;
                    end else if (tick_i.sample_high) begin
                        sda_o    <= 1'b0;
                        sda_en_o <= 1'b1;
                    end
                end
                D_ADDR_W, D_ADDR_R, W_ADDR, WR_DATA: begin
                    if (tick_i.sample_low) begin
                        if (in_data) begin
                            // msb first, ~index maps 0..7 to bit 7..0
                            sda_o    <= phase_i.tx_byte.data[~phase_i.half_bit[3:1]];
                            sda_en_o <= 1'b1;
                        end else begin
                            sda_o    <= 1'b1;       // slave owns the ack slot
                            sda_en_o <= 1'b0;
                        end
                    end
                end
                RD_DATA: begin
                    if (tick_i.sample_low) begin
                        if (in_data) begin
                            sda_o    <= 1'b1;
                            sda_en_o <= 1'b0;
                        end else begin
                            sda_o    <= phase_i.last_rd;  // nack the final byte
                            sda_en_o <= 1'b1;
                        end
                    end
                end
                STOP: begin
                    if (tick_i.sample_low) begin
                        sda_o    <= 1'b0;
                        sda_en_o <= 1'b1;
                    end else if (tick_i.sample_high) begin
                        sda_o    <= 1'b1;           // rising sda with scl high
                        sda_en_o <= 1'b0;
                    end
                end
                default: begin
                    sda_o    <= 1'b1;
                    sda_en_o <= 1'b0;
                end
            endcase
        end
    end

    // ========================================================================
    // read path
    // ========================================================================
    always_ff @(posedge clk) begin
        if ((phase_i.state == RD_DATA) && tick_i.sample_high && in_data)
            shift_q <= {shift_q[6:0], sda_i};
        if (rd_byte_done)
            rdata_o <= shift_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rvalid_o <= 1'b0;
        else
            rvalid_o <= rd_byte_done;  // one pulse per byte
    end

endmodule

`default_nettype wire

// ==== hdl/i2c_master_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_master_top import i2c_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,

    // host side
    input  wire logic       wen_i,
    input  wire logic       ren_i,
    input  i2c_req_t        req_i,
    input  wire logic [7:0] wdata_i,
    output logic            wvalid_o,
    output logic [7:0]      rdata_o,
    output logic            rvalid_o,

    // i2c bus, sda open drain
    output logic            scl_o,
    input  wire logic       sda_i,
    output logic            sda_o,
    output logic            sda_en_o,

    output logic            done_o,
    output logic            error_o
);

    logic       busy;
    i2c_tick_t  tick;
    i2c_phase_t phase;

    i2c_scl_gen scl_gen_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .busy_i   (busy),
        .tick_o   (tick)
    );

    i2c_seq_fsm seq_fsm_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wen_i    (wen_i),
        .ren_i    (ren_i),
        .req_i    (req_i),
        .wdata_i  (wdata_i),
        .sda_i    (sda_i),
        .tick_i   (tick),
        .phase_o  (phase),
        .busy_o   (busy),
        .done_o   (done_o),
        .error_o  (error_o),
        .wvalid_o (wvalid_o)
    );

    i2c_bit_engine bit_engine_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .phase_i  (phase),
        .tick_i   (tick),
        .sda_i    (sda_i),
        .sda_o    (sda_o),
        .sda_en_o (sda_en_o),
        .rdata_o  (rdata_o),
        .rvalid_o (rvalid_o)
    );

    assign scl_o = tick.scl;

endmodule

`default_nettype wire

// ==== hdl/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

    // ========================================================================
    // bus timing
    // ========================================================================
    localparam int SYS_CLK_HZ = 50_000_000;
    localparam int SCL_HZ     = 400_000;
    localparam int SCL_DIV    = SYS_CLK_HZ / SCL_HZ;   // 125 clocks per scl period
    localparam int CNT_W      = 16;

    localparam logic [CNT_W-1:0] SCL_FALL_AT    = CNT_W'(SCL_DIV / 2);
    localparam logic [CNT_W-1:0] SAMPLE_HIGH_AT = CNT_W'(SCL_DIV / 4 - 1);
    localparam logic [CNT_W-1:0] SAMPLE_LOW_AT  = CNT_W'(SCL_DIV * 3 / 4);

    // byte framing: 16 half-bits of data, 2 for the ack
    localparam int         BITS_PER_BYTE = 8;
    localparam logic [4:0] ACK_SLOT      = 5'd17;

    // ========================================================================
    // types
    // ========================================================================
    typedef enum logic [3:0] {
        IDLE,
        W_START,     // start before the device address
        R_START,     // repeated start of a random read
        D_ADDR_W,
        D_ADDR_R,
        W_ADDR,      // word address, one or two bytes
        WR_DATA,
        RD_DATA,
        STOP
    } i2c_state_e;

    typedef struct packed {
        logic [6:0]  dev_addr;
        logic [15:0] word_addr;      // high byte goes first
        logic        two_byte_addr;
        logic [7:0]  num_bytes_m1;
    } i2c_req_t;

    typedef struct packed {
        logic [6:0] addr;
        logic       rw;              // 1 = read
    } i2c_addr_byte_t;

    typedef union packed {
        logic [7:0]     data;
        i2c_addr_byte_t dev;
    } i2c_byte_u;

    typedef struct packed {
        logic scl;
        logic sample_high;           // middle of scl high
        logic sample_low;            // middle of scl low
    } i2c_tick_t;

    typedef struct packed {
        i2c_state_e state;
        logic [4:0] half_bit;        // 0..17
        logic       last_rd;
        i2c_byte_u  tx_byte;
    } i2c_phase_t;

endpackage

`default_nettype wire

// ==== hdl/i2c_scl_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_scl_gen import i2c_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      busy_i,
    output i2c_tick_t      tick_o
);

    logic [CNT_W-1:0] cnt_q;

    // ========================================================================
    // divider, parked at zero when no transfer runs
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (!busy_i) begin
            cnt_q <= '0;
        end else if (cnt_q == CNT_W'(SCL_DIV - 1)) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // scl high for the first half of the period, low for the second
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_o.scl <= 1'b1;
        end else if (!busy_i) begin
            tick_o.scl <= 1'b1;
        end else if (cnt_q == SCL_FALL_AT) begin
            tick_o.scl <= 1'b0;
        end else if (cnt_q == '0) begin
            tick_o.scl <= 1'b1;
        end
    end

    // one-cycle strobes at the quarter points
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_o.sample_high <= 1'b0;
            tick_o.sample_low  <= 1'b0;
        end else begin
            tick_o.sample_high <= busy_i && (cnt_q == SAMPLE_HIGH_AT);
            tick_o.sample_low  <= busy_i && (cnt_q == SAMPLE_LOW_AT);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/i2c_seq_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_seq_fsm import i2c_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       wen_i,
    input  wire logic       ren_i,
    input  i2c_req_t        req_i,
    input  wire logic [7:0] wdata_i,
    input  wire logic       sda_i,
    input  i2c_tick_t       tick_i,
    output i2c_phase_t      phase_o,
    output logic            busy_o,
    output logic            done_o,
    output logic            error_o,
    output logic            wvalid_o
);

    i2c_state_e state_q, state_d;
    logic [4:0] half_bit_q;
    logic       is_wr_q;            // latched at start, write wins over read
    logic       hi_pend_q;          // high word-address byte still to send
    logic [7:0] left_q;             // data bytes after the current one
    logic       in_byte;
    logic       byte_end;
    logic       ack;
    logic       start;
    i2c_byte_u  tx_byte;

    assign start    = (state_q == IDLE) && (wen_i || ren_i);
    assign in_byte  = state_q inside {D_ADDR_W, D_ADDR_R, W_ADDR, WR_DATA, RD_DATA};
    assign byte_end = in_byte && tick_i.sample_high && (half_bit_q == ACK_SLOT);
    assign ack      = !sda_i;       // slave pulls low to acknowledge
    assign busy_o   = (state_q != IDLE);

    // ========================================================================
    // next state
    // ========================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start)
                    state_d = W_START;
            end
            W_START: begin
                if (tick_i.sample_high)
                    state_d = D_ADDR_W;
            end
            R_START: begin
                if (tick_i.sample_high)
                    state_d = D_ADDR_R;
            end
            D_ADDR_W: begin
                if (byte_end)
                    state_d = ack ? W_ADDR : IDLE;
            end
            D_ADDR_R: begin
                if (byte_end)
                    state_d = ack ? RD_DATA : IDLE;
            end
            W_ADDR: begin
                if (byte_end) begin
                    if (!ack)
                        state_d = IDLE;
                    else if (hi_pend_q)
                        state_d = W_ADDR;   // low byte follows
                    else if (is_wr_q)
                        state_d = WR_DATA;
                    else
                        state_d = R_START;
                end
            end
            WR_DATA: begin
                if (byte_end) begin
                    if (!ack)
                        state_d = IDLE;
                    else
                        state_d = (left_q != '0) ? WR_DATA : STOP;
                end
            end
            RD_DATA: begin
                if (byte_end)
                    state_d = (left_q != '0) ? RD_DATA : STOP;
            end
            STOP: begin
                if (tick_i.sample_high)
                    state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    // half-bit position, one step per strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_bit_q <= '0;
        end else if (!in_byte) begin
            half_bit_q <= '0;
        end else if (tick_i.sample_high || tick_i.sample_low) begin
            half_bit_q <= (half_bit_q == ACK_SLOT) ? 5'd0 : half_bit_q + 5'd1;
        end
    end

    // ========================================================================
    // byte counters
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_wr_q   <= 1'b0;
            hi_pend_q <= 1'b0;
            left_q    <= '0;
        end else if (start) begin
            is_wr_q   <= wen_i;
            hi_pend_q <= req_i.two_byte_addr;
            left_q    <= req_i.num_bytes_m1;
        end else if (byte_end) begin
            if (state_q == W_ADDR)
                hi_pend_q <= 1'b0;
            if ((state_q inside {WR_DATA, RD_DATA}) && (left_q != '0))
                left_q <= left_q - 8'd1;
        end
    end

    // byte on the wire for the transmit states
    always_comb begin
        tx_byte.dev.addr = req_i.dev_addr;
        tx_byte.dev.rw   = (state_q == D_ADDR_R);
        if (state_q == W_ADDR)
            tx_byte.data = hi_pend_q ? req_i.word_addr[15:8] : req_i.word_addr[7:0];
        else if (state_q == WR_DATA)
            tx_byte.data = wdata_i;
    end

    assign phase_o.state    = state_q;
    assign phase_o.half_bit = half_bit_q;
    assign phase_o.last_rd  = (state_q == RD_DATA) && (left_q == '0);
    assign phase_o.tx_byte  = tx_byte;

    // ========================================================================
    // host strobes
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_o   <= 1'b0;
            error_o  <= 1'b0;
            wvalid_o <= 1'b0;
        end else begin
            done_o   <= (state_q == STOP) && tick_i.sample_high;
            error_o  <= byte_end && !ack && (state_q != RD_DATA);  // no stop after a nack
            wvalid_o <= byte_end && ack && (state_q == WR_DATA);
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/i2c_pkg.sv
hdl/i2c_scl_gen.sv
hdl/i2c_seq_fsm.sv
hdl/i2c_bit_engine.sv
hdl/i2c_master_top.sv
test/i2c_eeprom_model.sv
test/i2c_master_chk.sv
test/tb_i2c_master.sv

// ==== test/i2c_eeprom_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_eeprom_model #(
    parameter logic [6:0] DEV_ADDR = 7'h50
) (
    input  wire logic scl_i,
    input  wire logic sda_i,
    input  wire logic two_byte_i,       // word address width of the coming transfer
    output logic      sda_low_o
);

    typedef enum logic [2:0] {M_IDLE, M_DEV, M_ADDR_HI, M_ADDR_LO, M_WRITE, M_READ} mode_e;

    logic [7:0]  mem [0:65535];
    mode_e       mode       = M_IDLE;
    logic [15:0] ptr        = '0;
    logic [7:0]  shreg      = '0;
    logic [7:0]  rd_byte    = '0;
    int          bit_idx    = 0;        // rising edges seen in the current byte
    logic        sending    = 1'b0;
    logic        master_ack = 1'b0;
    logic        scl_q      = 1'b1;
    logic        sda_q      = 1'b1;

    initial begin
        sda_low_o = 1'b0;
        for (int a = 0; a < 65536; a++)
            mem[a] = 8'(a >> 8) ^ 8'(a) ^ 8'h5a;
    end

    // ========================================================================
    // byte handling
    // ========================================================================
    task automatic take_byte();
        case (mode)
            M_DEV: begin
                if (shreg[7:1] != DEV_ADDR) begin
                    mode = M_IDLE;              // not ours, stay off the bus
                    return;
                end
                if (shreg[0]) begin
                    mode       = M_READ;
                    master_ack = 1'b1;          // first byte goes out unasked
                    sending    = 1'b0;
                end else begin
                    mode = two_byte_i ? M_ADDR_HI : M_ADDR_LO;
                end
            end
            M_ADDR_HI: begin
                ptr[15:8] = shreg;
                mode      = M_ADDR_LO;
            end
            M_ADDR_LO: begin
                ptr[7:0] = shreg;
                if (!two_byte_i)
                    ptr[15:8] = 8'h00;
                mode = M_WRITE;
            end
            default: begin
                mem[ptr] = shreg;
                ptr      = ptr + 16'd1;
            end
        endcase
        sda_low_o = 1'b1;                       // ack
    endtask

    task automatic rise_edge();
        if (mode == M_IDLE)
            return;
        if (bit_idx < 8) begin
            if (mode != M_READ)
                shreg = {shreg[6:0], sda_i};
            bit_idx = bit_idx + 1;
        end else begin
            if (sending)
                master_ack = !sda_i;
            bit_idx = 0;
        end
    endtask

    task automatic fall_edge();
        sda_low_o = 1'b0;
        if (mode == M_IDLE)
            return;
        if (bit_idx == 8) begin
            if (mode != M_READ)
                take_byte();
        end else if (mode == M_READ) begin
            if (bit_idx == 0) begin
                if (!master_ack) begin
                    mode = M_IDLE;              // nack ends the read
                    return;
                end
                rd_byte = mem[ptr];
                ptr     = ptr + 16'd1;
                sending = 1'b1;
            end
            sda_low_o = !rd_byte[7 - bit_idx];
        end
    endtask

    // start and stop are sda edges while scl is high
    always @(scl_i or sda_i) begin
        if (scl_i && scl_q && sda_q && !sda_i) begin
            mode      = M_DEV;
            bit_idx   = 0;
            sending   = 1'b0;
            sda_low_o = 1'b0;
        end else if (scl_i && scl_q && !sda_q && sda_i) begin
            mode = M_IDLE;
        end else if (scl_i && !scl_q) begin
            rise_edge();
        end else if (!scl_i && scl_q) begin
            fall_edge();
        end
        scl_q = scl_i;
        sda_q = sda_i;
    end

endmodule

`default_nettype wire

// ==== test/i2c_master_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_master_chk import i2c_pkg::*; (
    input wire logic       clk,
    input wire logic       rst_n,
    input wire i2c_phase_t phase_i,
    input wire logic       scl_i,
    input wire logic       sda_en_i,
    input wire logic       done_i,
    input wire logic       error_i,
    input wire logic       wvalid_i,
    input wire logic       rvalid_i
);

    int unsigned fail_cnt = 0;
    logic        idle;

    assign idle = (phase_i.state == IDLE) && !sda_en_i;   // no transfer under way

    done_error_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(done_i && error_i))
        else begin
            fail_cnt++;
            $error("done and error were high in the same cycle");
        end

    write_read_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(wvalid_i && rvalid_i))
        else begin
            fail_cnt++;
            $error("wvalid and rvalid were high in the same cycle");
        end

    scl_high_idle: assert property (@(posedge clk) disable iff (!rst_n) idle |-> scl_i)
        else begin
            fail_cnt++;
            $error("scl was low while the controller was idle");
        end

endmodule

bind i2c_master_top i2c_master_chk chk_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .phase_i  (phase),
    .scl_i    (scl_o),
    .sda_en_i (sda_en_o),
    .done_i   (done_o),
    .error_i  (error_o),
    .wvalid_i (wvalid_o),
    .rvalid_i (rvalid_o)
);

`default_nettype wire

// ==== test/i2c_master_tests.txt ====
# op dev(hex) waddr(hex) two count(dec) nack data(hex, first byte leftmost)
# op W writes data, X writes random bytes, R reads and compares data, V reads back earlier writes
W 50 0010 0 4 0 a55a0ff0
R 50 0010 0 4 0 a55a0ff0
R 50 0012 0 2 0 0ff0
W 50 0123 1 3 0 c0ffee
W 50 0023 0 1 0 77
R 50 0123 1 3 0 c0ffee
R 50 0023 0 1 0 77
W 51 0040 0 2 1 1234
R 50 0011 0 1 0 5a
R 2a 0010 0 1 1 00
W 50 0080 0 1 0 3c
X 50 0400 1 16 0 0
V 50 0400 1 16 0 0
X 50 1000 1 256 0 0
V 50 1000 1 256 0 0

// ==== test/tb_i2c_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_i2c_master import i2c_pkg::*; ();

    localparam int          MAX_BYTES  = 256;
    localparam logic [31:0] SEED       = 32'h4ac0;
    localparam string       TESTS_FILE = "test/i2c_master_tests.txt";

    typedef struct packed {
        logic [7:0]    op;              // ascii letter
        logic [6:0]    dev;
        logic [15:0]   waddr;
        logic          two;
        logic [8:0]    count;           // 1..256
        logic          nack;
        logic [2047:0] data;            // first byte in the top used bits
    } test_t;

    logic       clk;
    logic       rst_n;
    logic       wen;
    logic       ren;
    i2c_req_t   req;
    logic [7:0] wdata;
    logic       wvalid;
    logic [7:0] rdata;
    logic       rvalid;
    logic       scl;
    logic       sda_bus;
    logic       sda_o;
    logic       sda_en;
    logic       done;
    logic       error;
    logic       slave_low;
    logic       two_byte;

    test_t       tests_q[$];
    logic [7:0]  shadow [0:65535];      // expected eeprom contents
    int unsigned val_errs   = 0;
    int unsigned setup_errs = 0;

    // pulled up and low when either side pulls
    assign sda_bus = ((sda_en && !sda_o) || slave_low) ? 1'b0 : 1'b1;

    i2c_master_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wen_i    (wen),
        .ren_i    (ren),
        .req_i    (req),
        .wdata_i  (wdata),
        .wvalid_o (wvalid),
        .rdata_o  (rdata),
        .rvalid_o (rvalid),
        .scl_o    (scl),
        .sda_i    (sda_bus),
        .sda_o    (sda_o),
        .sda_en_o (sda_en),
        .done_o   (done),
        .error_o  (error)
    );

    i2c_eeprom_model #(.DEV_ADDR(7'h50)) slave_i (
        .scl_i      (scl),
        .sda_i      (sda_bus),
        .two_byte_i (two_byte),
        .sda_low_o  (slave_low)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================================================
    // helpers
    // ========================================================================
    task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else begin
                val_errs++;
                $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            end
    endtask

    task automatic watchdog(input longint unsigned cycles);
        repeat (cycles) @(posedge clk);
        $display("Timeout: the run did not end within %0d clock cycles", cycles);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic load_tests();
        int            fd;
        int            fields;
        string         line;
        string         op;
        logic [6:0]    dev;
        logic [15:0]   waddr;
        int            two;
        int            cnt;
        int            nack;
        logic [2047:0] data;
        test_t         t;

        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            setup_errs++;
            $display("Cannot open the tests file %s", TESTS_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#")
                    continue;
                fields = $sscanf(line, "%s %h %h %d %d %d %h",
                                 op, dev, waddr, two, cnt, nack, data);
                if (fields != 7 || cnt < 1 || cnt > MAX_BYTES) begin
                    setup_errs++;
                    $display("Skipping a malformed line in the tests file: %s", line);
                end else begin
                    t.op    = op[0];
                    t.dev   = dev;
                    t.waddr = waddr;
                    t.two   = two[0];
                    t.count = 9'(cnt);
                    t.nack  = nack[0];
                    t.data  = data;
                    tests_q.push_back(t);
                end
            end
            $fclose(fd);
        end
    endtask

    // ========================================================================
    // one transfer from start pulse to done or error
    // ========================================================================
    task automatic run_transaction(input test_t t);
        logic [7:0]  bytes [0:MAX_BYTES-1];
        logic [15:0] base;
        int          n;
        int          n_wv     = 0;
        int          n_rv     = 0;
        int          n_done   = 0;
        int          n_err    = 0;
        bit          is_wr;
        bit          finished = 1'b0;

        n     = int'(t.count);
        is_wr = (t.op == "W") || (t.op == "X");
        base  = t.two ? t.waddr : {8'h00, t.waddr[7:0]};
        for (int i = 0; i < n; i++) begin
            if (t.op == "X")
                bytes[i] = 8'($urandom());
            else if (t.op == "V")
                bytes[i] = shadow[base + 16'(i)];
            else
                bytes[i] = t.data[(n - 1 - i) * 8 +: 8];
        end

        @(posedge clk);
        req      <= '{dev_addr: t.dev, word_addr: t.waddr, two_byte_addr: t.two,
                      num_bytes_m1: 8'(n - 1)};
        wdata    <= bytes[0];
        two_byte <= t.two;
        wen      <= is_wr;
        ren      <= !is_wr;
        @(posedge clk);
        wen <= 1'b0;
        ren <= 1'b0;

        while (!finished) begin
            @(negedge clk);
            if (rvalid) begin
                if (n_rv < n)
                    check_equal($sformatf("read byte %0d", n_rv), rdata, bytes[n_rv]);
                n_rv++;
            end
            if (done) begin
                n_done++;
                finished = 1'b1;
            end
            if (error) begin
                n_err++;
                finished = 1'b1;
            end
            if (wvalid) begin
                n_wv++;
                if (n_wv < n) begin
                    @(posedge clk);
                    wdata <= bytes[n_wv];       // next byte well before its first bit
                end
            end
        end

        check_equal("error pulses", n_err, t.nack);
        check_equal("done pulses", n_done, !t.nack);
        check_equal("wvalid pulses", n_wv, (is_wr && !t.nack) ? n : 0);
        check_equal("rvalid pulses", n_rv, (!is_wr && !t.nack) ? n : 0);
        if (is_wr && !t.nack) begin
            for (int i = 0; i < n; i++) begin
                check_equal($sformatf("eeprom byte at %04h", base + 16'(i)),
                            slave_i.mem[base + 16'(i)], bytes[i]);
                shadow[base + 16'(i)] = bytes[i];
            end
        end
        repeat (20) @(posedge clk);
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        longint unsigned budget;
        int unsigned     chk_errs;

        rst_n    = 1'b0;
        wen      = 1'b0;
        ren      = 1'b0;
        req      = '0;
        wdata    = '0;
        two_byte = 1'b0;
        void'($urandom(SEED));

        load_tests();
        if (tests_q.size() == 0) begin
            setup_errs++;
            $display("The tests file holds no transaction");
        end
        budget = 1000;
        foreach (tests_q[i])
            budget += (longint'(tests_q[i].count) + 4) * 9 * SCL_DIV * 3 / 2 + 200;
        fork
            watchdog(budget);
        join_none

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_equal("scl_o after reset", scl, 1'b1);
        check_equal("sda_o after reset", sda_o, 1'b1);
        check_equal("sda_en_o after reset", sda_en, 1'b0);
        check_equal("done_o after reset", done, 1'b0);
        check_equal("error_o after reset", error, 1'b0);
        check_equal("rvalid_o after reset", rvalid, 1'b0);
        check_equal("wvalid_o after reset", wvalid, 1'b0);

        foreach (tests_q[i])
            run_transaction(tests_q[i]);

        chk_errs = dut_i.chk_i.fail_cnt;
        $display("Errors: %0d value, %0d setup, %0d assertion", val_errs, setup_errs, chk_errs);
        if (val_errs == 0 && setup_errs == 0 && chk_errs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
